// ==== hub75_pkg.sv ====
package hub75_pkg;

    // red in 15..11, green in 10..5, blue in 4..0
    typedef logic [15:0] rgb565_t;

    localparam int BRIGHTNESS_PLANES = 6; // binary weighted planes per row
    localparam int BYTES_PER_PIXEL   = 2;

    // host command bytes
    localparam logic [7:0] CMD_LOAD       = 8'h4C; // full frame follows
    localparam logic [7:0] CMD_RGB_ENABLE = 8'h45; // arg bits 2..0 = b, g, r
    localparam logic [7:0] CMD_BRIGHTNESS = 8'h42; // arg bits 5..0 = plane mask

endpackage

// ==== uart_rx.sv ====
`timescale 1ns/1ps
module uart_rx #(
    parameter int CLKS_PER_BIT = 8,
    localparam int TW = $clog2(CLKS_PER_BIT)
) (
    input  logic       clk_in,
    input  logic       rst,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);
    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

    localparam logic [TW-1:0] HALF_BIT = TW'(CLKS_PER_BIT / 2 - 1);
    localparam logic [TW-1:0] FULL_BIT = TW'(CLKS_PER_BIT - 1);

    state_t        state;
    logic [1:0]    rx_sync; // two flop synchronizer
    logic          rx_s;
    logic [TW-1:0] tick;
    logic [2:0]    bit_idx;

    assign rx_s = rx_sync[1];

    always_ff @(posedge clk_in) begin
        rx_valid <= 1'b0;
        if (rst) begin
            state   <= IDLE;
            rx_sync <= 2'b11; // line idles high
            tick    <= '0;
            bit_idx <= '0;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            tick    <= tick + 1'b1;
            case (state)
                IDLE: begin
                    tick <= '0;
                    if (!rx_s) state <= START;
                end
                START: if (tick == HALF_BIT) begin
                    tick  <= '0;
                    state <= rx_s ? IDLE : DATA; // short glitch rather than a start bit
                end
                DATA: if (tick == FULL_BIT) begin
                    tick    <= '0;
                    rx_data <= {rx_s, rx_data[7:1]}; // lsb first
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) state <= STOP;
                end
                STOP: if (tick == FULL_BIT) begin
                    rx_valid <= rx_s; // bad stop bit drops the byte
                    state    <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== control_module.sv ====
`timescale 1ns/1ps
module control_module #(
    parameter int PIXEL_WIDTH = 8,
    parameter int PIXEL_HALFHEIGHT = 2,
    localparam int FRAME_BYTES =
        PIXEL_WIDTH * PIXEL_HALFHEIGHT * 2 * hub75_pkg::BYTES_PER_PIXEL,
    localparam int AW = $clog2(FRAME_BYTES)
) (
    input  logic                                    clk_in,
    input  logic                                    rst,
    input  logic [7:0]                              rx_data,
    input  logic                                    rx_valid,
    output logic [AW-1:0]                           ram_wr_addr,
    output logic [7:0]                              ram_wr_data,
    output logic                                    ram_wr_en,
    output logic [2:0]                              rgb_enable,
    output logic [hub75_pkg::BRIGHTNESS_PLANES-1:0] brightness_enable
);
    import hub75_pkg::*;

    typedef enum logic [1:0] {WAIT_CMD, LOAD_DATA, RGB_ARG, BRIGHT_ARG} state_t;

    localparam logic [AW-1:0] LAST_BYTE = AW'(FRAME_BYTES - 1);

    state_t        state;
    logic [AW-1:0] byte_addr; // next byte slot of the frame

    always_ff @(posedge clk_in) begin
        if (rst) begin
            state             <= WAIT_CMD;
            byte_addr         <= '0;
            ram_wr_en         <= 1'b0;
            rgb_enable        <= '1;
            brightness_enable <= '1;
        end else begin
            ram_wr_en <= 1'b0;
            if (rx_valid) begin
                case (state)
                    WAIT_CMD: begin
                        byte_addr <= '0;
                        case (rx_data)
                            CMD_LOAD:       state <= LOAD_DATA;
                            CMD_RGB_ENABLE: state <= RGB_ARG;
                            CMD_BRIGHTNESS: state <= BRIGHT_ARG;
                            default:        state <= WAIT_CMD; // stray byte
                        endcase
                    end
                    LOAD_DATA: begin
                        // high byte of each pixel arrives first
                        ram_wr_addr <= byte_addr;
                        ram_wr_data <= rx_data;
                        ram_wr_en   <= 1'b1;
                        byte_addr   <= byte_addr + 1'b1;
                        if (byte_addr == LAST_BYTE) state <= WAIT_CMD;
                    end
                    RGB_ARG: begin
                        rgb_enable <= rx_data[2:0];
                        state      <= WAIT_CMD;
                    end
                    BRIGHT_ARG: begin
                        brightness_enable <= rx_data[BRIGHTNESS_PLANES-1:0];
                        state             <= WAIT_CMD;
                    end
                    default: state <= WAIT_CMD;
                endcase
            end
        end
    end

endmodule

// ==== framebuffer_ram.sv ====
`timescale 1ns/1ps
module framebuffer_ram #(
    parameter int PIXEL_WIDTH = 8,
    parameter int PIXEL_HALFHEIGHT = 2,
    localparam int PIXELS = PIXEL_WIDTH * PIXEL_HALFHEIGHT * 2,
    localparam int RAW = $clog2(PIXELS),
    localparam int AW = $clog2(PIXELS * hub75_pkg::BYTES_PER_PIXEL)
) (
    input  logic               clk_in,
    input  logic [AW-1:0]      wr_addr,
    input  logic [7:0]         wr_data,
    input  logic               wr_en,
    input  logic [RAW-1:0]     rd_addr,
    output hub75_pkg::rgb565_t rd_data
);
    import hub75_pkg::*;

    rgb565_t        mem [PIXELS];
    logic [RAW-1:0] wr_word;

    assign wr_word = wr_addr[AW-1:1]; // byte address to pixel index

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            if (wr_addr[0]) begin
                mem[wr_word][7:0] <= wr_data; // odd byte is the low half
            end else begin
                mem[wr_word][15:8] <= wr_data;
            end
        end
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== scan_timer.sv ====
`timescale 1ns/1ps
module scan_timer #(
    parameter int PIXEL_WIDTH = 8,
    parameter int PIXEL_HALFHEIGHT = 2,
    parameter int BASE_TICKS = 4,
    localparam int CW = $clog2(PIXEL_WIDTH),
    localparam int RW = $clog2(PIXEL_HALFHEIGHT),
    localparam int PW = $clog2(hub75_pkg::BRIGHTNESS_PLANES)
) (
    input  logic          clk_in,
    input  logic          rst,
    input  logic          col_step,
    input  logic          line_step,
    input  logic          on_start,
    output logic [CW-1:0] column,
    output logic [RW-1:0] row,
    output logic [PW-1:0] plane,
    output logic          col_last,
    output logic          on_done
);
    import hub75_pkg::*;

    // wide enough for the on-time of the top plane
    localparam int OW = $clog2(BASE_TICKS << (BRIGHTNESS_PLANES - 1)) + 1;

    logic [OW-1:0] on_cnt;

    assign col_last = column == CW'(PIXEL_WIDTH - 1);
    assign on_done  = on_cnt == OW'(1); // last display cycle

    always_ff @(posedge clk_in) begin
        if (rst) begin
            column <= '0;
            row    <= '0;
            plane  <= '0;
            on_cnt <= '0;
        end else begin
            if (line_step) begin
                column <= '0;
                if (plane == PW'(BRIGHTNESS_PLANES - 1)) begin
                    plane <= '0;
                    row   <= (row == RW'(PIXEL_HALFHEIGHT - 1)) ? '0 : row + 1'b1;
                end else begin
                    plane <= plane + 1'b1;
                end
            end else if (col_step) begin
                column <= column + 1'b1;
            end

            if (on_start) begin
                on_cnt <= OW'(BASE_TICKS) << plane; // binary weighted on-time
            end else if (on_cnt != '0) begin
                on_cnt <= on_cnt - 1'b1;
            end
        end
    end

endmodule

// ==== matrix_scan.sv ====
`timescale 1ns/1ps
module matrix_scan #(
    parameter int PIXEL_HALFHEIGHT = 2,
    localparam int RW = $clog2(PIXEL_HALFHEIGHT)
) (
    input  logic          clk_in,
    input  logic          rst,
    input  logic          load_ack,
    input  logic          col_last,
    input  logic          on_done,
    input  logic [RW-1:0] row,
    output logic          load_req,
    output logic          col_step,
    output logic          line_step,
    output logic          on_start,
    output logic          clk_pixel,
    output logic          row_latch,
    output logic          output_enable,
    output logic [RW-1:0] row_address_active
);
    typedef enum logic [3:0] {
        IDLE, FETCH, RELEASE, SETTLE, CLK_HI, CLK_LO, BLANK, LATCH, DISPLAY
    } state_t;

    state_t state;
    state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:    state_next = FETCH;
            FETCH:   if (load_ack) state_next = RELEASE;  // pixels held from here
            RELEASE: if (!load_ack) state_next = SETTLE;
            SETTLE:  state_next = CLK_HI;
            CLK_HI:  state_next = CLK_LO;
            CLK_LO:  state_next = col_last ? BLANK : FETCH;
            BLANK:   state_next = LATCH;
            LATCH:   state_next = DISPLAY;
            DISPLAY: if (on_done) state_next = FETCH;
            default: state_next = IDLE;
        endcase
    end

    // panel strobes decoded from the state register
    assign load_req      = state == FETCH;
    assign clk_pixel     = state == CLK_HI;
    assign col_step      = (state == CLK_LO) && !col_last;
    assign row_latch     = state == LATCH;
    assign on_start      = state == LATCH; // on-time counter loads with the latch
    assign output_enable = state == DISPLAY;
    assign line_step     = (state == DISPLAY) && on_done;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            state              <= IDLE;
            row_address_active <= '0;
        end else begin
            state <= state_next;
            if (state == LATCH) row_address_active <= row;
        end
    end

endmodule

// ==== framebuffer_fetch.sv ====
`timescale 1ns/1ps
module framebuffer_fetch #(
    parameter int PIXEL_WIDTH = 8,
    parameter int PIXEL_HALFHEIGHT = 2,
    localparam int CW = $clog2(PIXEL_WIDTH),
    localparam int RW = $clog2(PIXEL_HALFHEIGHT),
    localparam int RAW = $clog2(PIXEL_WIDTH * PIXEL_HALFHEIGHT * 2)
) (
    input  logic               clk_in,
    input  logic               rst,
    input  logic               load_req,
    input  logic [CW-1:0]      column,
    input  logic [RW-1:0]      row,
    input  hub75_pkg::rgb565_t ram_rd_data,
    output logic               load_ack,
    output logic [RAW-1:0]     ram_rd_addr,
    output hub75_pkg::rgb565_t rgb565_top,
    output hub75_pkg::rgb565_t rgb565_bottom
);
    typedef enum logic [2:0] {IDLE, RD_TOP, RD_BOT, CAP_BOT, ACK} state_t;

    // bottom half starts PIXEL_HALFHEIGHT rows further on
    localparam logic [RAW-1:0] HALF_OFFSET = RAW'(PIXEL_WIDTH * PIXEL_HALFHEIGHT);

    state_t         state;
    logic [RAW-1:0] top_addr;

    assign top_addr    = RAW'(row) * RAW'(PIXEL_WIDTH) + RAW'(column);
    assign ram_rd_addr = (state == RD_BOT) ? top_addr + HALF_OFFSET : top_addr;
    assign load_ack    = state == ACK;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (load_req) state <= RD_TOP;
                RD_TOP:  state <= RD_BOT;
                RD_BOT:  state <= CAP_BOT;
                CAP_BOT: state <= ACK;
                ACK:     if (!load_req) state <= IDLE; // four phase return
                default: state <= IDLE;
            endcase
        end
    end

    // ram data lags the address by one cycle
    always_ff @(posedge clk_in) begin
        if (state == RD_BOT) rgb565_top <= ram_rd_data;
        if (state == CAP_BOT) rgb565_bottom <= ram_rd_data;
    end

endmodule

// ==== pixel_split.sv ====
`timescale 1ns/1ps
module pixel_split (
    input  hub75_pkg::rgb565_t                              pixel,
    input  logic [$clog2(hub75_pkg::BRIGHTNESS_PLANES)-1:0] plane,
    input  logic [2:0]                                      rgb_enable,
    input  logic [hub75_pkg::BRIGHTNESS_PLANES-1:0]         brightness_enable,
    output logic [2:0]                                      rgb_out
);
    import hub75_pkg::*;

    logic [4:0]                           red;
    logic [5:0]                           green;
    logic [4:0]                           blue;
    logic [$clog2(BRIGHTNESS_PLANES)-1:0] plane_m1;
    logic                                 plane_on;

    assign {red, green, blue} = pixel;
    assign plane_m1 = plane - 1'b1; // 5-bit red and blue sit one plane up
    assign plane_on = brightness_enable[plane];

    assign rgb_out[0] = (plane != '0) && red[plane_m1] && rgb_enable[0] && plane_on;
    assign rgb_out[1] = green[plane] && rgb_enable[1] && plane_on;
    assign rgb_out[2] = (plane != '0) && blue[plane_m1] && rgb_enable[2] && plane_on;

endmodule

// ==== hub75_top.sv ====
`timescale 1ns/1ps
module hub75_top #(
    parameter int PIXEL_WIDTH = 8,
    parameter int PIXEL_HALFHEIGHT = 2,
    parameter int CLKS_PER_BIT = 8,
    parameter int BASE_TICKS = 4
) (
    input  logic                                clk_in,
    input  logic                                rst,
    input  logic                                uart_rx,
    output logic [2:0]                          rgb1,
    output logic [2:0]                          rgb2,
    output logic [$clog2(PIXEL_HALFHEIGHT)-1:0] row_address_active,
    output logic                                clk_pixel,
    output logic                                row_latch,
    output logic                                output_enable
);
    import hub75_pkg::*;

    localparam int PIXELS = PIXEL_WIDTH * PIXEL_HALFHEIGHT * 2;
    localparam int AW     = $clog2(PIXELS * BYTES_PER_PIXEL);
    localparam int RAW    = $clog2(PIXELS);
    localparam int CW     = $clog2(PIXEL_WIDTH);
    localparam int RW     = $clog2(PIXEL_HALFHEIGHT);
    localparam int PW     = $clog2(BRIGHTNESS_PLANES);

    logic [7:0]                   rx_data;
    logic                         rx_valid;
    logic [AW-1:0]                ram_wr_addr;
    logic [7:0]                   ram_wr_data;
    logic                         ram_wr_en;
    logic [RAW-1:0]               ram_rd_addr;
    rgb565_t                      ram_rd_data;
    logic [2:0]                   rgb_enable;
    logic [BRIGHTNESS_PLANES-1:0] brightness_enable;
    logic                         load_req;
    logic                         load_ack;
    logic                         col_step;
    logic                         line_step;
    logic                         on_start;
    logic                         col_last;
    logic                         on_done;
    logic [CW-1:0]                column;
    logic [RW-1:0]                row;
    logic [PW-1:0]                plane;
    rgb565_t                      pixel_top;
    rgb565_t                      pixel_bottom;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) rx_i (
        .clk_in(clk_in), .rst(rst), .rx(uart_rx),
        .rx_data(rx_data), .rx_valid(rx_valid)
    );

    control_module #(.PIXEL_WIDTH(PIXEL_WIDTH), .PIXEL_HALFHEIGHT(PIXEL_HALFHEIGHT)) ctrl_i (
        .clk_in(clk_in), .rst(rst), .rx_data(rx_data), .rx_valid(rx_valid),
        .ram_wr_addr(ram_wr_addr), .ram_wr_data(ram_wr_data), .ram_wr_en(ram_wr_en),
        .rgb_enable(rgb_enable), .brightness_enable(brightness_enable)
    );

    framebuffer_ram #(.PIXEL_WIDTH(PIXEL_WIDTH), .PIXEL_HALFHEIGHT(PIXEL_HALFHEIGHT)) fb_i (
        .clk_in(clk_in), .wr_addr(ram_wr_addr), .wr_data(ram_wr_data), .wr_en(ram_wr_en),
        .rd_addr(ram_rd_addr), .rd_data(ram_rd_data)
    );

    scan_timer #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HALFHEIGHT(PIXEL_HALFHEIGHT),
        .BASE_TICKS(BASE_TICKS)
    ) timer_i (
        .clk_in(clk_in), .rst(rst),
        .col_step(col_step), .line_step(line_step), .on_start(on_start),
        .column(column), .row(row), .plane(plane),
        .col_last(col_last), .on_done(on_done)
    );

    matrix_scan #(.PIXEL_HALFHEIGHT(PIXEL_HALFHEIGHT)) scan_i (
        .clk_in(clk_in), .rst(rst),
        .load_ack(load_ack), .col_last(col_last), .on_done(on_done), .row(row),
        .load_req(load_req), .col_step(col_step), .line_step(line_step),
        .on_start(on_start), .clk_pixel(clk_pixel), .row_latch(row_latch),
        .output_enable(output_enable), .row_address_active(row_address_active)
    );

    framebuffer_fetch #(.PIXEL_WIDTH(PIXEL_WIDTH), .PIXEL_HALFHEIGHT(PIXEL_HALFHEIGHT)) fetch_i (
        .clk_in(clk_in), .rst(rst), .load_req(load_req),
        .column(column), .row(row), .ram_rd_data(ram_rd_data),
        .load_ack(load_ack), .ram_rd_addr(ram_rd_addr),
        .rgb565_top(pixel_top), .rgb565_bottom(pixel_bottom)
    );

    // one splitter per half panel
    pixel_split split_top_i (
        .pixel(pixel_top), .plane(plane), .rgb_enable(rgb_enable),
        .brightness_enable(brightness_enable), .rgb_out(rgb1)
    );

    pixel_split split_bot_i (
        .pixel(pixel_bottom), .plane(plane), .rgb_enable(rgb_enable),
        .brightness_enable(brightness_enable), .rgb_out(rgb2)
    );

endmodule

// ==== tb_hub75.sv ====
`timescale 1ns/1ps
module tb_hub75;
    import hub75_pkg::*;

    localparam int PIXEL_WIDTH      = 8;
    localparam int PIXEL_HALFHEIGHT = 2;
    localparam int CLKS_PER_BIT     = 8;
    localparam int BASE_TICKS       = 4;
    localparam int RW     = $clog2(PIXEL_HALFHEIGHT);
    localparam int CW     = $clog2(PIXEL_WIDTH);
    localparam int PW     = $clog2(BRIGHTNESS_PLANES);
    localparam int PIXELS = PIXEL_WIDTH * PIXEL_HALFHEIGHT * 2;
    localparam int FW     = $clog2(PIXELS);
    localparam int LINES_PER_SCAN = PIXEL_HALFHEIGHT * BRIGHTNESS_PLANES;
    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 8;
    localparam int SEED           = 31;
    // two frame loads, four two-byte commands, three stray bytes
    localparam int UART_BYTES   = 2 * (1 + 2 * PIXELS) + 11;
    localparam int FRAME_CYCLES = PIXEL_HALFHEIGHT * (BRIGHTNESS_PLANES * (PIXEL_WIDTH * 12 + 4)
                                  + BASE_TICKS * ((1 << BRIGHTNESS_PLANES) - 1));
    localparam int SCAN_CHECKS  = 5;
    localparam int WATCHDOG_CYCLES =
        2 * (UART_BYTES * 10 * CLKS_PER_BIT + (SCAN_CHECKS + 3) * FRAME_CYCLES + 100);

    logic          clk_in;
    logic          rst;
    logic          uart_rx;
    logic [2:0]    rgb1;
    logic [2:0]    rgb2;
    logic [RW-1:0] row_address_active;
    logic          clk_pixel;
    logic          row_latch;
    logic          output_enable;

    logic [15:0]                  frame [PIXELS]; // host copy of the framebuffer
    logic [2:0]                   exp_rgb_en;
    logic [BRIGHTNESS_PLANES-1:0] exp_bright_en;
    int                           chk_lo; // latch numbers whose lines get compared
    int                           chk_hi;
    int                           test_errors;
    int                           test_checks;

    // panel monitor state
    logic [2:0] top_cols [PIXEL_WIDTH];
    logic [2:0] bot_cols [PIXEL_WIDTH];
    int         shift_cnt = 0;
    int         oe_len = 0;
    int         latch_count = 0;
    int         trk_row = 0;
    int         trk_plane = 0;
    int         disp_plane = 0;
    int         latched_row = 0;
    int         mon_errors = 0;
    int         mon_checks = 0;
    logic       row_pending = 1'b0;

    hub75_top #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HALFHEIGHT(PIXEL_HALFHEIGHT),
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .BASE_TICKS(BASE_TICKS)
    ) dut_i (
        .clk_in(clk_in), .rst(rst), .uart_rx(uart_rx),
        .rgb1(rgb1), .rgb2(rgb2), .row_address_active(row_address_active),
        .clk_pixel(clk_pixel), .row_latch(row_latch), .output_enable(output_enable)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    // colour bits the panel should see for one pixel in one plane
    function automatic logic [2:0] expected_rgb(input logic [15:0] pix, input logic [PW-1:0] pl);
        logic [5:0] red6;
        logic [5:0] green;
        logic [5:0] blue6;
        logic [2:0] bits;
        red6  = {pix[15:11], 1'b0}; // 5-bit channels have no plane 0 weight
        green = pix[10:5];
        blue6 = {pix[4:0], 1'b0};
        bits  = {blue6[pl], green[pl], red6[pl]} & exp_rgb_en;
        if (!exp_bright_en[pl]) bits = 3'b000;
        return bits;
    endfunction

    task automatic check_line();
        logic [2:0] exp_t;
        logic [2:0] exp_b;
        mon_checks++;
        if (shift_cnt != PIXEL_WIDTH) begin
            mon_errors++;
            $display("ERR %0t: %0d pixel clocks in line, expected %0d", $time, shift_cnt,
                     PIXEL_WIDTH);
        end
        if (latch_count > 1) begin
            mon_checks++;
            if (oe_len != (BASE_TICKS << disp_plane)) begin
                mon_errors++;
                $display("ERR %0t: output enable high %0d cycles in plane %0d, expected %0d",
                         $time, oe_len, disp_plane, BASE_TICKS << disp_plane);
            end
        end
        if (latch_count >= chk_lo && latch_count <= chk_hi) begin
            for (int c = 0; c < PIXEL_WIDTH; c++) begin
                exp_t = expected_rgb(frame[FW'(trk_row * PIXEL_WIDTH + c)], PW'(trk_plane));
                exp_b = expected_rgb(frame[FW'((trk_row + PIXEL_HALFHEIGHT) * PIXEL_WIDTH + c)],
                                     PW'(trk_plane));
                mon_checks += 2;
                if (top_cols[CW'(c)] !== exp_t || bot_cols[CW'(c)] !== exp_b) begin
                    mon_errors++;
                    $display("ERR %0t: row %0d plane %0d col %0d rgb1 %b rgb2 %b, expected %b %b",
                             $time, trk_row, trk_plane, c, top_cols[CW'(c)], bot_cols[CW'(c)],
                             exp_t, exp_b);
                end
            end
        end
        latched_row = trk_row;
        disp_plane  = trk_plane;
        row_pending = 1'b1;
        shift_cnt   = 0;
        oe_len      = 0;
        if (trk_plane == BRIGHTNESS_PLANES - 1) begin // row moves on after the top plane
            trk_plane = 0;
            trk_row   = (trk_row + 1) % PIXEL_HALFHEIGHT;
        end else begin
            trk_plane++;
        end
    endtask

    // outputs are sampled mid-cycle where they are settled
    always @(negedge clk_in) begin
        if (!rst) begin
            if (row_pending) begin
                row_pending = 1'b0;
                mon_checks++;
                if (row_address_active !== RW'(latched_row)) begin
                    mon_errors++;
                    $display("ERR %0t: row address %0d, expected %0d", $time,
                             row_address_active, latched_row);
                end
            end
            if (output_enable) oe_len++;
            if (clk_pixel) begin
                mon_checks++;
                if (output_enable !== 1'b0) begin
                    mon_errors++;
                    $display("ERR %0t: output enable high at pixel clock", $time);
                end
                if (shift_cnt < PIXEL_WIDTH) begin
                    top_cols[CW'(shift_cnt)] = rgb1;
                    bot_cols[CW'(shift_cnt)] = rgb2;
                end
                shift_cnt++;
            end
            if (row_latch) begin
                latch_count++;
                check_line();
            end
        end
    end

    task automatic send_byte(input logic [7:0] data);
        logic [9:0] bits;
        bits = {1'b1, data, 1'b0}; // start bit first and then data lsb first
        repeat (10) begin
            uart_rx <= bits[0];
            bits = bits >> 1;
            repeat (CLKS_PER_BIT) @(posedge clk_in);
        end
    endtask

    task automatic send_command(input logic [7:0] cmd, input logic [7:0] arg);
        send_byte(cmd);
        send_byte(arg);
        repeat (4) @(posedge clk_in); // let the parser take the argument
    endtask

    task automatic load_frame();
        logic [31:0] rnd;
        logic [15:0] pix;
        send_byte(CMD_LOAD);
        for (int p = 0; p < PIXELS; p++) begin
            rnd = $urandom();
            pix = rnd[15:0];
            frame[FW'(p)] = pix;
            send_byte(pix[15:8]);
            send_byte(pix[7:0]);
        end
        repeat (4) @(posedge clk_in);
    endtask

    // compare one full scan of lines fetched after this point
    task automatic scan_check();
        chk_lo = latch_count + 2; // the line in flight may be torn
        chk_hi = latch_count + 1 + LINES_PER_SCAN;
        while (latch_count < chk_hi) @(posedge clk_in);
    endtask

    task automatic check_idle_strobes();
        test_checks++;
        if (clk_pixel !== 1'b0 || row_latch !== 1'b0 || output_enable !== 1'b0) begin
            test_errors++;
            $display("ERR %0t: panel strobe active around reset", $time);
        end
    endtask

    task automatic test_reset();
        for (int i = 0; i < RESET_CYCLES - 1; i++) begin
            @(posedge clk_in);
            @(negedge clk_in);
            check_idle_strobes();
        end
        @(posedge clk_in);
        rst <= 1'b0;
        repeat (3) begin
            @(negedge clk_in);
            check_idle_strobes();
        end
        while (latch_count < 1) @(posedge clk_in);
        @(negedge clk_in);
        test_checks++;
        if (row_address_active !== '0) begin
            test_errors++;
            $display("ERR %0t: first latch shows row %0d", $time, row_address_active);
        end
        @(posedge clk_in);
    endtask

    task automatic test_frame_load();
        load_frame();
        scan_check();
    endtask

    task automatic test_rgb_enable();
        send_command(CMD_RGB_ENABLE, 8'h05);
        exp_rgb_en = 3'b101; // green off
        scan_check();
        send_command(CMD_RGB_ENABLE, 8'h07);
        exp_rgb_en = 3'b111;
    endtask

    task automatic test_brightness();
        send_command(CMD_BRIGHTNESS, 8'h0F);
        exp_bright_en = 6'b001111; // planes 4 and 5 dark
        scan_check();
        send_command(CMD_BRIGHTNESS, 8'h3F);
        exp_bright_en = 6'b111111;
    endtask

    // one scan from latch to latch shows every plane of every row once
    task automatic test_on_time();
        int total;
        int lines;
        int expected;
        total    = 0;
        lines    = 0;
        expected = 0;
        for (int p = 0; p < BRIGHTNESS_PLANES; p++) begin
            expected += PIXEL_HALFHEIGHT * (BASE_TICKS << p);
        end
        @(negedge clk_in);
        while (row_latch !== 1'b1) @(negedge clk_in);
        while (lines < LINES_PER_SCAN) begin
            @(negedge clk_in);
            if (output_enable === 1'b1) total++;
            if (row_latch === 1'b1) lines++;
        end
        test_checks++;
        if (total != expected) begin
            test_errors++;
            $display("ERR %0t: output enable high %0d cycles over one scan, expected %0d",
                     $time, total, expected);
        end
        @(posedge clk_in);
    endtask

    task automatic test_reload();
        send_byte(8'h00);
        send_byte(8'h13);
        send_byte(8'hA5);
        load_frame();
        scan_check();
    endtask

    initial begin
        rst           <= 1'b1;
        uart_rx       <= 1'b1;
        exp_rgb_en    = '1;
        exp_bright_en = '1;
        chk_lo        = 1;
        chk_hi        = 0;
        test_errors   = 0;
        test_checks   = 0;
        void'($urandom(SEED));
        test_reset();
        test_frame_load();
        test_rgb_enable();
        test_brightness();
        test_on_time();
        test_reload();
        $display("checks %0d, monitor errors %0d, test errors %0d",
                 mon_checks + test_checks, mon_errors, test_errors);
        if (mon_errors + test_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hub75_pkg.sv
uart_rx.sv
control_module.sv
framebuffer_ram.sv
scan_timer.sv
matrix_scan.sv
framebuffer_fetch.sv
pixel_split.sv
hub75_top.sv
tb_hub75.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it and scan the log
LOG=sim.log

verilator --binary --timing -f vlog.f --top-module tb_hub75 -Mdir obj_dir -o tb_hub75
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_hub75 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    exit 1
fi
exit 0
